// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    localparam int DEFAULT_XLEN = 64;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
    localparam logic [6:0] OPC_OP32    = 7'b0111011;

    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_SLL   = 4'd2;
    localparam logic [3:0] ALU_SLT   = 4'd3;
    localparam logic [3:0] ALU_SLTU  = 4'd4;
    localparam logic [3:0] ALU_XOR   = 4'd5;
    localparam logic [3:0] ALU_SRL   = 4'd6;
    localparam logic [3:0] ALU_SRA   = 4'd7;
    localparam logic [3:0] ALU_OR    = 4'd8;
    localparam logic [3:0] ALU_AND   = 4'd9;
    localparam logic [3:0] ALU_PASSB = 4'd10;  // result is operand b

    localparam logic [1:0] SEL_A_RS1  = 2'd0;
    localparam logic [1:0] SEL_A_PC   = 2'd1;
    localparam logic [1:0] SEL_A_ZERO = 2'd2;
    localparam logic [1:0] SEL_B_RS2  = 2'd0;
    localparam logic [1:0] SEL_B_IMM  = 2'd1;
    localparam logic [1:0] SEL_B_FOUR = 2'd2;

    // load/store width, same encoding as funct3
    localparam logic [2:0] MEM_B  = 3'b000;
    localparam logic [2:0] MEM_H  = 3'b001;
    localparam logic [2:0] MEM_W  = 3'b010;
    localparam logic [2:0] MEM_D  = 3'b011;
    localparam logic [2:0] MEM_BU = 3'b100;
    localparam logic [2:0] MEM_HU = 3'b101;
    localparam logic [2:0] MEM_WU = 3'b110;

    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

    // one instruction word, six format views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

// ==== verilog/id_ex_if.sv ====
`timescale 1ns/10ps

interface id_ex_if import rv_pkg::*; #(
    parameter int XLEN = DEFAULT_XLEN
);

    logic            valid;
    logic [3:0]      alu_op;
    logic [1:0]      sel_a;
    logic [1:0]      sel_b;
    logic            word_op;         // 32-bit op, result sign-extended
    logic            rd_write;
    logic            mem_read;
    logic [7:0]      mem_write_mask;
    logic [2:0]      mem_size;
    logic            branch;
    logic [2:0]      branch_cond;
    logic            jal;
    logic            jalr;
    logic [XLEN-1:0] imm;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] pc;

    modport producer (
        output valid, alu_op, sel_a, sel_b, word_op, rd_write, mem_read, mem_write_mask,
               mem_size, branch, branch_cond, jal, jalr, imm, rs1_addr, rs2_addr, rd_addr, pc
    );

    // register side of the pipeline stage
    modport stage (
        output valid, alu_op, sel_a, sel_b, word_op, rd_write, mem_read, mem_write_mask,
               mem_size, branch, branch_cond, jal, jalr, imm, rs1_addr, rs2_addr, rd_addr, pc
    );

    modport consumer (
        input valid, alu_op, sel_a, sel_b, word_op, rd_write, mem_read, mem_write_mask,
              mem_size, branch, branch_cond, jal, jalr, imm, rs1_addr, rs2_addr, rd_addr, pc
    );

endinterface

// ==== verilog/inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode import rv_pkg::*; #(
    parameter int XLEN = DEFAULT_XLEN
) (
    input  logic            instr_valid_i,
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    id_ex_if.producer       dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            legal;
    logic            sub_bit;
    logic [3:0]      arith_op;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;

    assign imm_i = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{(XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {{(XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11, instr_i.b.imm_10_5,
                    instr_i.b.imm_4_1, 1'b0};
    assign imm_u = {{(XLEN-32){instr_i.u.imm[19]}}, instr_i.u.imm, 12'b0};
    assign imm_j = {{(XLEN-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12, instr_i.j.imm_11,
                    instr_i.j.imm_10_1, 1'b0};

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_OPIMM, OPC_OP: legal = 1'b1;
            OPC_JALR:    legal = (funct3 == 3'b000);
            OPC_BRANCH:  legal = funct3 inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
            OPC_LOAD:    legal = funct3 inside {MEM_B, MEM_H, MEM_W, MEM_D, MEM_BU, MEM_HU, MEM_WU};
            OPC_STORE:   legal = funct3 inside {MEM_B, MEM_H, MEM_W, MEM_D};
            OPC_OPIMM32, OPC_OP32: legal = funct3 inside {3'b000, 3'b001, 3'b101};
            default:     legal = 1'b0;
        endcase
    end

    // bit 30 picks sub only for register-register ops
    assign sub_bit = instr_i.r.funct7[5] & ((opcode == OPC_OP) | (opcode == OPC_OP32));

    always_comb begin
        case (funct3)
            3'b000:  arith_op = sub_bit ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec.valid          = 1'b0;
        dec.alu_op         = ALU_ADD;
        dec.sel_a          = SEL_A_RS1;
        dec.sel_b          = SEL_B_RS2;
        dec.word_op        = 1'b0;
        dec.rd_write       = 1'b0;
        dec.mem_read       = 1'b0;
        dec.mem_write_mask = 8'h00;
        dec.mem_size       = 3'b000;
        dec.branch         = 1'b0;
        dec.branch_cond    = 3'b000;
        dec.jal            = 1'b0;
        dec.jalr           = 1'b0;
        dec.imm            = '0;
        dec.rs1_addr       = 5'd0;
        dec.rs2_addr       = 5'd0;
        dec.rd_addr        = 5'd0;
        dec.pc             = '0;
        if (instr_valid_i && legal) begin
            dec.valid = 1'b1;
            dec.pc    = pc_i;
            case (opcode)
                OPC_LUI, OPC_AUIPC: begin
                    dec.sel_a    = (opcode == OPC_LUI) ? SEL_A_ZERO : SEL_A_PC;
                    dec.sel_b    = SEL_B_IMM;
                    dec.alu_op   = (opcode == OPC_LUI) ? ALU_PASSB : ALU_ADD;
                    dec.imm      = imm_u;
                    dec.rd_write = 1'b1;
                    dec.rd_addr  = instr_i.u.rd;
                end
                OPC_JAL, OPC_JALR: begin
                    dec.jal      = (opcode == OPC_JAL);
                    dec.jalr     = (opcode == OPC_JALR);
                    dec.sel_a    = SEL_A_PC;     // link value pc+4
                    dec.sel_b    = SEL_B_FOUR;
                    dec.imm      = (opcode == OPC_JAL) ? imm_j : imm_i;
                    dec.rs1_addr = (opcode == OPC_JALR) ? instr_i.i.rs1 : 5'd0;
                    dec.rd_write = 1'b1;
                    dec.rd_addr  = instr_i.j.rd;
                end
                OPC_BRANCH: begin
                    dec.branch      = 1'b1;
                    dec.branch_cond = funct3;
                    dec.imm         = imm_b;
                    dec.rs1_addr    = instr_i.b.rs1;
                    dec.rs2_addr    = instr_i.b.rs2;
                end
                OPC_LOAD: begin
                    dec.mem_read = 1'b1;
                    dec.mem_size = funct3;
                    dec.sel_b    = SEL_B_IMM;    // address rs1+imm
                    dec.imm      = imm_i;
                    dec.rs1_addr = instr_i.i.rs1;
                    dec.rd_write = 1'b1;
                    dec.rd_addr  = instr_i.i.rd;
                end
                OPC_STORE: begin
                    case (funct3)
                        MEM_B:   dec.mem_write_mask = 8'h01;
                        MEM_H:   dec.mem_write_mask = 8'h03;
                        MEM_W:   dec.mem_write_mask = 8'h0f;
                        default: dec.mem_write_mask = 8'hff;
                    endcase
                    dec.mem_size = funct3;
                    dec.sel_b    = SEL_B_IMM;
                    dec.imm      = imm_s;
                    dec.rs1_addr = instr_i.s.rs1;
                    dec.rs2_addr = instr_i.s.rs2;
                end
                OPC_OPIMM, OPC_OPIMM32: begin
                    dec.word_op  = (opcode == OPC_OPIMM32);
                    dec.alu_op   = arith_op;
                    dec.sel_b    = SEL_B_IMM;
                    dec.imm      = imm_i;        // shamt sits in the low bits
                    dec.rs1_addr = instr_i.i.rs1;
                    dec.rd_write = 1'b1;
                    dec.rd_addr  = instr_i.i.rd;
                end
                default: begin                   // OP and OP-32
                    dec.word_op  = (opcode == OPC_OP32);
                    dec.alu_op   = arith_op;
                    dec.rs1_addr = instr_i.r.rs1;
                    dec.rs2_addr = instr_i.r.rs2;
                    dec.rd_write = 1'b1;
                    dec.rd_addr  = instr_i.r.rd;
                end
            endcase
        end
    end

endmodule

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/10ps

module id_ex_reg (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  logic     clear_i,
    id_ex_if.consumer d,
    id_ex_if.stage    q
);

    logic zero_entry;

    // hold beats flush and clear, reset beats everything
    assign zero_entry = reset_i | (~hold_i & (flush_i | clear_i));

    always_ff @(posedge clk) begin
        if (zero_entry) begin
            q.valid          <= 1'b0;
            q.alu_op         <= '0;
            q.sel_a          <= '0;
            q.sel_b          <= '0;
            q.word_op        <= 1'b0;
            q.rd_write       <= 1'b0;
            q.mem_read       <= 1'b0;
            q.mem_write_mask <= '0;
            q.mem_size       <= '0;
            q.branch         <= 1'b0;
            q.branch_cond    <= '0;
            q.jal            <= 1'b0;
            q.jalr           <= 1'b0;
            q.imm            <= '0;
            q.rs1_addr       <= '0;
            q.rs2_addr       <= '0;
            q.rd_addr        <= '0;
            q.pc             <= '0;
        end else if (!hold_i) begin
            q.valid          <= d.valid;
            q.alu_op         <= d.alu_op;
            q.sel_a          <= d.sel_a;
            q.sel_b          <= d.sel_b;
            q.word_op        <= d.word_op;
            q.rd_write       <= d.rd_write;
            q.mem_read       <= d.mem_read;
            q.mem_write_mask <= d.mem_write_mask;
            q.mem_size       <= d.mem_size;
            q.branch         <= d.branch;
            q.branch_cond    <= d.branch_cond;
            q.jal            <= d.jal;
            q.jalr           <= d.jalr;
            q.imm            <= d.imm;
            q.rs1_addr       <= d.rs1_addr;
            q.rs2_addr       <= d.rs2_addr;
            q.rd_addr        <= d.rd_addr;
            q.pc             <= d.pc;
        end
    end

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input  logic [4:0] dec_rs1_i,
    input  logic [4:0] dec_rs2_i,
    input  logic       dec_valid_i,
    input  logic       mem_busy_i,
    input  logic       taken_i,
    id_ex_if.consumer  ex,
    output logic       hold_o,
    output logic       flush_o,
    output logic       clear_o,
    output logic       stall_o,
    output logic       redirect_o
);

    logic load_use;

    // unused source fields decode to x0 and never match a nonzero rd
    assign load_use = ex.valid & ex.mem_read & (ex.rd_addr != 5'd0) & dec_valid_i &
                      ((dec_rs1_i == ex.rd_addr) | (dec_rs2_i == ex.rd_addr));

    assign hold_o     = mem_busy_i;
    assign redirect_o = taken_i & ~mem_busy_i;
    assign flush_o    = redirect_o;                // kill wrong-path slot
    assign clear_o    = load_use & ~hold_o & ~flush_o;

    // upstream keeps the same instruction presented
    assign stall_o = mem_busy_i | load_use;

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit import rv_pkg::*; #(
    parameter int XLEN = DEFAULT_XLEN
) (
    id_ex_if.consumer       ex,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic [XLEN-1:0] alu_result_o,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o,
    output logic [XLEN-1:0] store_data_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] a_lo_s;
    logic [XLEN-1:0] a_lo_z;
    logic [XLEN-1:0] alu_raw;
    logic [XLEN-1:0] jalr_sum;
    logic [5:0]      shamt;
    logic            cond;

    always_comb begin
        case (ex.sel_a)
            SEL_A_RS1: op_a = rs1_data_i;
            SEL_A_PC:  op_a = ex.pc;
            default:   op_a = '0;
        endcase
        case (ex.sel_b)
            SEL_B_RS2:  op_b = rs2_data_i;
            SEL_B_IMM:  op_b = ex.imm;
            SEL_B_FOUR: op_b = XLEN'(4);
            default:    op_b = '0;
        endcase
    end

    // word shifts see only the low half of a
    assign a_lo_s = {{(XLEN-32){op_a[31]}}, op_a[31:0]};
    assign a_lo_z = {{(XLEN-32){1'b0}}, op_a[31:0]};
    assign shamt  = ex.word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:   alu_raw = op_a + op_b;
            ALU_SUB:   alu_raw = op_a - op_b;
            ALU_SLL:   alu_raw = op_a << shamt;
            ALU_SLT:   alu_raw = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:  alu_raw = XLEN'(op_a < op_b);
            ALU_XOR:   alu_raw = op_a ^ op_b;
            ALU_SRL:   alu_raw = (ex.word_op ? a_lo_z : op_a) >> shamt;
            ALU_SRA:   alu_raw = $signed(ex.word_op ? a_lo_s : op_a) >>> shamt;
            ALU_OR:    alu_raw = op_a | op_b;
            ALU_AND:   alu_raw = op_a & op_b;
            ALU_PASSB: alu_raw = op_b;
            default:   alu_raw = '0;
        endcase
    end

    assign alu_result_o = ex.word_op ? {{(XLEN-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

    always_comb begin
        case (ex.branch_cond)
            BR_EQ:   cond = (rs1_data_i == rs2_data_i);
            BR_NE:   cond = (rs1_data_i != rs2_data_i);
            BR_LT:   cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_GE:   cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            BR_LTU:  cond = (rs1_data_i < rs2_data_i);
            BR_GEU:  cond = (rs1_data_i >= rs2_data_i);
            default: cond = 1'b0;
        endcase
    end

    assign taken_o = ex.valid & (ex.jal | ex.jalr | (ex.branch & cond));

    assign jalr_sum = rs1_data_i + ex.imm;
    assign target_o = ex.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : ex.pc + ex.imm;

    assign store_data_o = rs2_data_i;

endmodule

// ==== verilog/decode_exec_top.sv ====
`timescale 1ns/10ps

module decode_exec_top import rv_pkg::*; #(
    parameter int XLEN = DEFAULT_XLEN
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic            mem_busy_i,
    output logic            ex_valid_o,
    output logic [XLEN-1:0] alu_result_o,
    output logic [4:0]      rd_addr_o,
    output logic            rd_write_o,
    output logic            mem_read_o,
    output logic [7:0]      mem_write_mask_o,
    output logic [2:0]      mem_size_o,
    output logic [XLEN-1:0] store_data_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic            stall_o,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o
);

    logic hold;
    logic flush;
    logic clear;
    logic taken;

    id_ex_if #(.XLEN(XLEN)) dec_bus ();
    id_ex_if #(.XLEN(XLEN)) ex_bus ();

    inst_decode #(.XLEN(XLEN)) i_inst_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .dec           (dec_bus)
    );

    id_ex_reg i_id_ex_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold),
        .flush_i (flush),
        .clear_i (clear),
        .d       (dec_bus),
        .q       (ex_bus)
    );

    hazard_unit i_hazard_unit (
        .dec_rs1_i   (dec_bus.rs1_addr),
        .dec_rs2_i   (dec_bus.rs2_addr),
        .dec_valid_i (dec_bus.valid),
        .mem_busy_i  (mem_busy_i),
        .taken_i     (taken),
        .ex          (ex_bus),
        .hold_o      (hold),
        .flush_o     (flush),
        .clear_o     (clear),
        .stall_o     (stall_o),
        .redirect_o  (redirect_o)
    );

    exec_unit #(.XLEN(XLEN)) i_exec_unit (
        .ex           (ex_bus),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .alu_result_o (alu_result_o),
        .taken_o      (taken),
        .target_o     (redirect_pc_o),
        .store_data_o (store_data_o)
    );

    assign ex_valid_o       = ex_bus.valid;
    assign rd_addr_o        = ex_bus.rd_addr;
    assign rd_write_o       = ex_bus.rd_write;
    assign mem_read_o       = ex_bus.mem_read;
    assign mem_write_mask_o = ex_bus.mem_write_mask;
    assign mem_size_o       = ex_bus.mem_size;
    assign rs1_addr_o       = ex_bus.rs1_addr;    // register file read port
    assign rs2_addr_o       = ex_bus.rs2_addr;

endmodule

// ==== test/decode_exec_asserts.sv ====
`timescale 1ns/10ps

module decode_exec_asserts #(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            reset_i,
    input logic            mem_busy_i,
    input logic            ex_valid_o,
    input logic            rd_write_o,
    input logic            mem_read_o,
    input logic [7:0]      mem_write_mask_o,
    input logic [2:0]      mem_size_o,
    input logic            redirect_o,
    input logic            stall_o,
    input logic [XLEN-1:0] alu_result_o,
    input logic [XLEN-1:0] redirect_pc_o,
    input logic [XLEN-1:0] store_data_o,
    input logic [4:0]      rd_addr_o
);

    int error_count = 0;

    a_reset_quiet: assert property (@(posedge clk)
        reset_i |=> !ex_valid_o && !redirect_o && !rd_write_o && !mem_read_o &&
                    mem_write_mask_o == 8'h00 && (!stall_o || mem_busy_i))
        else begin
            $error("outputs not quiet after reset");
            error_count++;
        end

    // load-use stall is one empty slot, never two
    a_load_use_gap: assert property (@(posedge clk) disable iff (reset_i)
        (stall_o && !mem_busy_i) |=> !ex_valid_o && (!stall_o || mem_busy_i))
        else begin
            $error("load-use stall did not produce exactly one bubble");
            error_count++;
        end

    a_flush_slot: assert property (@(posedge clk) disable iff (reset_i)
        redirect_o |=> !ex_valid_o)
        else begin
            $error("wrong-path slot not flushed after redirect");
            error_count++;
        end

    a_busy_stall: assert property (@(posedge clk) disable iff (reset_i)
        mem_busy_i |-> stall_o && !redirect_o)
        else begin
            $error("busy memory without stall or with redirect");
            error_count++;
        end

    a_busy_hold: assert property (@(posedge clk) disable iff (reset_i)
        mem_busy_i |=> $stable(ex_valid_o) && $stable(alu_result_o) && $stable(rd_addr_o) &&
                       $stable(rd_write_o) && $stable(mem_size_o) &&
                       $stable(redirect_pc_o) && $stable(store_data_o) &&
                       $stable(mem_write_mask_o) && $stable(mem_read_o))
        else begin
            $error("execute outputs changed while memory busy");
            error_count++;
        end

endmodule

// ==== test/tb_decode_exec.sv ====
`timescale 1ns/10ps

module tb_decode_exec import rv_pkg::*; ();

    localparam int XLEN    = 64;
    localparam int N_INSTR = 300;
    localparam int TIMEOUT = 4 * N_INSTR + 50;

    logic            clk;
    logic            reset_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] rs2_data_i;
    logic            mem_busy_i;
    logic            ex_valid_o;
    logic [XLEN-1:0] alu_result_o;
    logic [4:0]      rd_addr_o;
    logic            rd_write_o;
    logic            mem_read_o;
    logic [7:0]      mem_write_mask_o;
    logic [2:0]      mem_size_o;
    logic [XLEN-1:0] store_data_o;
    logic            redirect_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic            stall_o;
    logic [4:0]      rs1_addr_o;
    logic [4:0]      rs2_addr_o;

    logic [63:0] rng_state = 64'd82;
    logic [63:0] regs [0:31];
    logic [63:0] next_pc;
    int          n_done;
    int          busy_left;
    logic        need_new;

    // presented instruction (p_) and the model of the ID/EX entry (e_)
    logic        p_valid, p_alt, p_word;
    logic [6:0]  p_op;
    logic [2:0]  p_f3;
    logic [4:0]  p_rd, p_rs1, p_rs2;
    logic [63:0] p_imm, p_pc;
    logic        e_valid, e_alt, e_word;
    logic [6:0]  e_op;
    logic [2:0]  e_f3;
    logic [4:0]  e_rd, e_rs1, e_rs2;
    logic [63:0] e_imm, e_pc;

    decode_exec_top #(.XLEN(XLEN)) i_decode_exec_top (.*);

    bind decode_exec_top decode_exec_asserts #(.XLEN(XLEN)) i_decode_exec_asserts (.*);

    assign rs1_data_i = regs[rs1_addr_o];   // register file answers in the same cycle
    assign rs2_data_i = regs[rs2_addr_o];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [63:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic logic [63:0] sext32(logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [63:0] alu_ref(logic [2:0] f3, logic alt, logic word,
                                            logic [63:0] a, logic [63:0] b);
        logic [63:0] r;
        logic [5:0]  sh;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = {63'b0, $signed(a) < $signed(b)};
            3'd3: r = {63'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt && word)
                    r = $signed(sext32(a[31:0])) >>> sh;
                else if (alt)
                    r = $signed(a) >>> sh;
                else if (word)
                    r = {32'b0, a[31:0]} >> sh;
                else
                    r = a >> sh;
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return word ? sext32(r[31:0]) : r;
    endfunction

    function automatic logic cond_ref(logic [2:0] f3, logic [63:0] a, logic [63:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    task automatic gen_instr();
        instr_u      w;
        logic [63:0] r;
        logic [20:0] jimm;
        logic [12:0] bimm;
        logic [11:0] imm12;
        int          k;
        r = xorshift();
        k = int'(r[7:0]) % 11;
        w = '0;
        p_valid = (r[11:8] != 4'd0);
        p_alt = 1'b0;
        p_word = (k == 8) || (k == 10);
        p_rd = {2'b0, r[18:16]};
        p_rs1 = {2'b0, r[21:19]};
        p_rs2 = {2'b0, r[24:22]};
        p_f3 = r[27:25];
        imm12 = r[43:32];
        p_imm = {{52{imm12[11]}}, imm12};
        p_pc = next_pc;
        next_pc = next_pc + 4;
        if (k == 8 || k == 10)
            p_f3 = (r[26:25] == 2'd0) ? 3'd0 : (r[25] ? 3'd1 : 3'd5);  // word ops
        if (k == 7 || k == 8) begin
            if (p_f3 == 3'd1 || p_f3 == 3'd5) begin
                p_alt = (p_f3 == 3'd5) & r[28];
                imm12 = k == 8 ? {1'b0, p_alt, 5'b0, r[36:32]} : {1'b0, p_alt, 4'b0, r[37:32]};
                p_imm = {52'b0, imm12};
            end
        end
        if (k == 9 || k == 10)
            p_alt = r[28] & (p_f3 == 3'd0 || p_f3 == 3'd5);
        case (k)
            0, 1: begin
                p_op = (k == 0) ? OPC_LUI : OPC_AUIPC;
                p_imm = {{32{r[63]}}, r[63:44], 12'b0};
                p_rs1 = 5'd0;
                p_rs2 = 5'd0;
                w.u.imm = r[63:44];
            end
            2: begin
                p_op = OPC_JAL;
                jimm = {r[52:33], 1'b0};
                p_imm = {{43{jimm[20]}}, jimm};
                p_rs1 = 5'd0;
                p_rs2 = 5'd0;
                w.j.imm_20 = jimm[20];
                w.j.imm_10_1 = jimm[10:1];
                w.j.imm_11 = jimm[11];
                w.j.imm_19_12 = jimm[19:12];
            end
            4: begin
                p_op = OPC_BRANCH;
                if (p_f3 == 3'd2 || p_f3 == 3'd3)
                    p_f3 = p_f3 + 3'd2;
                bimm = {r[44:33], 1'b0};
                p_imm = {{51{bimm[12]}}, bimm};
                p_rd = 5'd0;
                w.b.imm_12 = bimm[12];
                w.b.imm_10_5 = bimm[10:5];
                w.b.imm_4_1 = bimm[4:1];
                w.b.imm_11 = bimm[11];
            end
            6: begin
                p_op = OPC_STORE;
                p_f3 = {1'b0, r[26:25]};
                p_rd = 5'd0;
                w.s.imm_hi = imm12[11:5];
                w.s.imm_lo = imm12[4:0];
            end
            9, 10: begin
                p_op = (k == 9) ? OPC_OP : OPC_OP32;
                w.r.funct7 = {1'b0, p_alt, 5'b0};
            end
            default: begin                           // I format
                p_op = (k == 3) ? OPC_JALR : (k == 5) ? OPC_LOAD :
                       (k == 7) ? OPC_OPIMM : OPC_OPIMM32;
                if (k == 3)
                    p_f3 = 3'd0;
                if (k == 5 && p_f3 == 3'd7)
                    p_f3 = 3'd6;
                p_rs2 = 5'd0;
                w.i.imm = imm12;
            end
        endcase
        w.r.opcode = p_op;
        w.r.funct3 = (k <= 2) ? w.r.funct3 : p_f3;
        if (k > 2) begin
            w.r.rs1 = p_rs1;
            if (k == 4 || k == 6 || k >= 9)
                w.r.rs2 = p_rs2;
        end
        if (k <= 2 || p_rd != 5'd0)
            w.r.rd = p_rd;
        instr_valid_i = p_valid;
        instr_i = w;
        pc_i = p_pc;
    endtask

    task automatic check_cycle();
        logic [63:0] a, b, res, tgt;
        logic        taken, lu;
        a = regs[e_rs1];
        b = regs[e_rs2];
        taken = e_valid && (e_op == OPC_JAL || e_op == OPC_JALR ||
                            (e_op == OPC_BRANCH && cond_ref(e_f3, a, b)));
        lu = e_valid && e_op == OPC_LOAD && e_rd != 5'd0 && p_valid &&
             (p_rs1 == e_rd || p_rs2 == e_rd);
        if (i_decode_exec_top.i_decode_exec_asserts.error_count != 0)
            stop_run("a bound protocol assertion failed");
        check_value("stall_o", stall_o, mem_busy_i | lu);
        check_value("redirect_o", redirect_o, taken & ~mem_busy_i);
        check_value("ex_valid_o", ex_valid_o, e_valid);
        if (e_valid) begin
            case (e_op)
                OPC_LUI:                res = e_imm;
                OPC_AUIPC:              res = e_pc + e_imm;
                OPC_JAL, OPC_JALR:      res = e_pc + 4;
                OPC_LOAD, OPC_STORE:    res = a + e_imm;     // effective address
                OPC_OPIMM, OPC_OPIMM32: res = alu_ref(e_f3, e_alt, e_word, a, e_imm);
                default:                res = alu_ref(e_f3, e_alt, e_word, a, b);
            endcase
            tgt = (e_op == OPC_JALR) ? ((a + e_imm) & ~64'h1) : e_pc + e_imm;
            check_value("rs1_addr_o", rs1_addr_o, e_rs1);
            check_value("rs2_addr_o", rs2_addr_o, e_rs2);
            check_value("rd_write_o", rd_write_o, e_op != OPC_BRANCH && e_op != OPC_STORE);
            check_value("rd_addr_o", rd_addr_o, e_rd);
            check_value("mem_read_o", mem_read_o, e_op == OPC_LOAD);
            check_value("mem_write_mask_o", mem_write_mask_o,
                        (e_op == OPC_STORE) ? (64'd1 << (8'd1 << e_f3)) - 1 : 64'd0);
            if (e_op == OPC_LOAD || e_op == OPC_STORE)
                check_value("mem_size_o", mem_size_o, e_f3);
            if (e_op == OPC_STORE)
                check_value("store_data_o", store_data_o, b);
            if (e_op != OPC_BRANCH)
                check_value("alu_result_o", alu_result_o, res);
            if (taken)
                check_value("redirect_pc_o", redirect_pc_o, tgt);
        end
        need_new = !mem_busy_i && !lu;
        if (!mem_busy_i) begin
            e_valid = p_valid && !taken && !lu;
            if (e_valid) begin
                {e_op, e_f3, e_alt, e_word} = {p_op, p_f3, p_alt, p_word};
                {e_rd, e_rs1, e_rs2, e_imm, e_pc} = {p_rd, p_rs1, p_rs2, p_imm, p_pc};
                n_done++;
            end
        end
    endtask

    initial begin
        reset_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        mem_busy_i = 1'b0;
        p_valid = 1'b0;
        e_valid = 1'b0;
        n_done = 0;
        busy_left = 0;
        next_pc = 64'h1000;
        for (int i = 0; i < 32; i++)
            regs[i] = (i == 0) ? 64'd0 : (i % 3 == 0) ? 64'd5 : xorshift();
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        gen_instr();
        while (n_done < N_INSTR) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            #2;
            if (busy_left == 0 && xorshift() % 8 == 0)
                busy_left = 1 + int'(xorshift() % 3);
            mem_busy_i = (busy_left != 0);
            if (busy_left != 0)
                busy_left--;
            if (need_new)
                gen_instr();
        end
        @(negedge clk);
        check_cycle();
        if (i_decode_exec_top.i_decode_exec_asserts.error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_run("a bound protocol assertion failed");
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        stop_run("timeout before all instructions were accepted");
    end

endmodule

// ==== all.f ====
verilog/rv_pkg.sv
verilog/id_ex_if.sv
verilog/inst_decode.sv
verilog/id_ex_reg.sv
verilog/hazard_unit.sv
verilog/exec_unit.sv
verilog/decode_exec_top.sv
test/decode_exec_asserts.sv
test/tb_decode_exec.sv

// ==== Bender.yml ====
package:
  name: decode_exec

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/id_ex_if.sv
      - verilog/inst_decode.sv
      - verilog/id_ex_reg.sv
      - verilog/hazard_unit.sv
      - verilog/exec_unit.sv
      - verilog/decode_exec_top.sv
  - target: test
    files:
      - test/decode_exec_asserts.sv
      - test/tb_decode_exec.sv
